// File: sources.f
+incdir+common
common/mbox_pkg.sv
design/mbox_decode.sv
design/mbox_execute.sv
design/mbox_result.sv
design/mbox_top.sv
testbench/mbox_top_checker.sv
testbench/mbox_top_tb.sv

// File: testbench/mbox_top_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "mbox_defs.svh"

module mbox_top_tb
    import mbox_pkg::*;
;

    localparam int NUM_ENTRIES  = 25;
    localparam int RESET_CYCLES = 8;
    localparam int CYCLE_LIMIT  = NUM_ENTRIES * 20 + RESET_CYCLES;

    localparam logic [`MBOX_USER_W-1:0] USER_A = 8'h1a;
    localparam logic [`MBOX_USER_W-1:0] USER_B = 8'h2b;

    // One command and the response it should produce
    typedef struct packed {
        mbox_op_e                op;
        logic [`MBOX_USER_W-1:0] user;
        logic [`MBOX_ADDR_W-1:0] addr;
        logic [3:0]              stall;
        logic                    is_data;
        mbox_status_e            status;
        logic                    held;
        logic [`MBOX_USER_W-1:0] owner;
    } entry_t;

    typedef struct packed {
        mbox_op_e                op;
        logic [`MBOX_USER_W-1:0] user;
        logic                    is_data;
        logic [`MBOX_DATA_W-1:0] rd_data;
        mbox_status_e            status;
        logic                    held;
        logic [`MBOX_USER_W-1:0] owner;
    } exp_rsp_t;

    logic       core_clk;
    logic       reset;
    logic       req_valid;
    logic       req_ready;
    mbox_req_t  req;
    logic       rsp_valid;
    logic       rsp_ready;
    mbox_rsp_t  rsp;
    logic [7:0] err_count;

    entry_t                  tbl [NUM_ENTRIES];
    int                      num_added;
    exp_rsp_t                exp_q [$];
    logic [`MBOX_DATA_W-1:0] tb_mem [`MBOX_DEPTH];
    int                      cycles;
    int unsigned             seed_val;

    mbox_top DUT (
        .clk       (core_clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp),
        .err_count (err_count)
    );

    initial
    begin
        core_clk = 1'b0;
        forever #2 core_clk = ~core_clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        string line;
        if (actual !== expected)
        begin
            line = $sformatf("Fail at %0t ns: %s = 0x%0h, expected 0x%0h",
                             $time, name, actual, expected);
            abort_run(line);
        end
    endtask

    task automatic add_entry(input mbox_op_e op, input logic [7:0] user,
                             input logic [5:0] addr, input logic [3:0] stall,
                             input logic is_data, input mbox_status_e status,
                             input logic held, input logic [7:0] owner);
        tbl[num_added] = '{op, user, addr, stall, is_data, status, held, owner};
        num_added++;
    endtask

    task automatic fill_table();
        num_added = 0;
        // Lock acquisition and contention
        add_entry(LOCK,   USER_A, 6'd0,  4'd0, 1'b0, OK,        1'b1, USER_A);
        add_entry(LOCK,   USER_B, 6'd0,  4'd0, 1'b0, BUSY,      1'b1, USER_A);
        // Owner writes then reads back, with back-pressure
        add_entry(WRITE,  USER_A, 6'd3,  4'd0, 1'b0, OK,        1'b1, USER_A);
        add_entry(WRITE,  USER_A, 6'd17, 4'd0, 1'b0, OK,        1'b1, USER_A);
        add_entry(WRITE,  USER_A, 6'd63, 4'd2, 1'b0, OK,        1'b1, USER_A);
        add_entry(READ,   USER_A, 6'd3,  4'd0, 1'b1, OK,        1'b1, USER_A);
        add_entry(READ,   USER_A, 6'd17, 4'd6, 1'b1, OK,        1'b1, USER_A);
        add_entry(READ,   USER_A, 6'd63, 4'd0, 1'b1, OK,        1'b1, USER_A);
        // Non-owner access leaves memory alone
        add_entry(WRITE,  USER_B, 6'd17, 4'd3, 1'b0, NOT_OWNER, 1'b1, USER_A);
        add_entry(READ,   USER_B, 6'd3,  4'd1, 1'b0, NOT_OWNER, 1'b1, USER_A);
        add_entry(READ,   USER_A, 6'd17, 4'd0, 1'b1, OK,        1'b1, USER_A);
        // Unlock rules and hand-over
        add_entry(UNLOCK, USER_B, 6'd0,  4'd4, 1'b0, NOT_OWNER, 1'b1, USER_A);
        add_entry(UNLOCK, USER_A, 6'd0,  4'd0, 1'b0, OK,        1'b0, 8'h00);
        add_entry(LOCK,   USER_B, 6'd0,  4'd2, 1'b0, OK,        1'b1, USER_B);
        add_entry(WRITE,  USER_B, 6'd0,  4'd0, 1'b0, OK,        1'b1, USER_B);
        add_entry(WRITE,  USER_B, 6'd40, 4'd5, 1'b0, OK,        1'b1, USER_B);
        add_entry(READ,   USER_A, 6'd0,  4'd0, 1'b0, NOT_OWNER, 1'b1, USER_B);
        add_entry(LOCK,   USER_A, 6'd0,  4'd1, 1'b0, BUSY,      1'b1, USER_B);
        add_entry(READ,   USER_B, 6'd0,  4'd0, 1'b1, OK,        1'b1, USER_B);
        add_entry(READ,   USER_B, 6'd40, 4'd0, 1'b1, OK,        1'b1, USER_B);
        add_entry(WRITE,  USER_B, 6'd40, 4'd3, 1'b0, OK,        1'b1, USER_B);
        add_entry(READ,   USER_B, 6'd40, 4'd0, 1'b1, OK,        1'b1, USER_B);
        add_entry(UNLOCK, USER_B, 6'd0,  4'd0, 1'b0, OK,        1'b0, 8'h00);
        add_entry(LOCK,   USER_A, 6'd0,  4'd2, 1'b0, OK,        1'b1, USER_A);
        add_entry(LOCK,   USER_A, 6'd0,  4'd0, 1'b0, OK,        1'b1, USER_A);
    endtask

    // Rejected commands that the error counter should see
    function automatic int count_rejects();
        int n;
        n = 0;
        for (int i = 0; i < NUM_ENTRIES; i++)
        begin
            if (!tbl[i].is_data && (tbl[i].status == BUSY || tbl[i].status == NOT_OWNER))
                n++;
        end
        return n;
    endfunction

    task automatic drive_requests();
        mbox_req_t r;
        exp_rsp_t  e;
        for (int i = 0; i < NUM_ENTRIES; i++)
        begin
            r.op   = tbl[i].op;
            r.user = tbl[i].user;
            r.addr = tbl[i].addr;
            r.data = $urandom;
            e.op      = tbl[i].op;
            e.user    = tbl[i].user;
            e.is_data = tbl[i].is_data;
            e.rd_data = tbl[i].is_data ? tb_mem[tbl[i].addr] : '0;
            e.status  = tbl[i].status;
            e.held    = tbl[i].held;
            e.owner   = tbl[i].owner;
            // Only an owner write reaches the memory
            if (tbl[i].op == WRITE && tbl[i].status == OK)
                tb_mem[tbl[i].addr] = r.data;
            req_valid <= 1'b1;
            req       <= r;
            do
                @(posedge core_clk);
            while (!req_ready);
            exp_q.push_back(e);
        end
        req_valid <= 1'b0;
    endtask

    task automatic compare_response(input exp_rsp_t e);
        check_value("rsp.op", 32'(rsp.op), 32'(e.op));
        check_value("rsp.user", 32'(rsp.user), 32'(e.user));
        check_value("rsp.is_data", 32'(rsp.is_data), 32'(e.is_data));
        if (e.is_data)
        begin
            check_value("rsp.payload.rd_data", rsp.payload.rd_data, e.rd_data);
        end
        else
        begin
            check_value("rsp.payload.stat.status", 32'(rsp.payload.stat.status),
                        32'(e.status));
            check_value("rsp.payload.stat.lock_held", 32'(rsp.payload.stat.lock_held),
                        32'(e.held));
            check_value("rsp.payload.stat.owner", 32'(rsp.payload.stat.owner),
                        32'(e.owner));
        end
    endtask

    // Takes responses in order, holding rsp_ready low for each entry's stall count
    task automatic collect_responses();
        int       idx;
        int       stall_left;
        exp_rsp_t e;
        idx        = 0;
        stall_left = tbl[0].stall;
        while (idx < NUM_ENTRIES)
        begin
            @(posedge core_clk);
            if (rsp_valid && rsp_ready)
            begin
                if (exp_q.size() == 0)
                    abort_run("A response arrived with no request outstanding");
                e = exp_q.pop_front();
                compare_response(e);
                idx++;
                if (idx < NUM_ENTRIES)
                    stall_left = tbl[idx].stall;
            end
            if (stall_left > 0)
            begin
                rsp_ready <= 1'b0;
                stall_left--;
            end
            else
            begin
                rsp_ready <= 1'b1;
            end
        end
    endtask

    initial
    begin
        cycles = 0;
        forever
        begin
            @(posedge core_clk);
            cycles++;
            if (cycles >= CYCLE_LIMIT)
                abort_run($sformatf("Timeout: responses not complete after %0d cycles",
                                    CYCLE_LIMIT));
        end
    end

    initial
    begin
        seed_val   = $urandom(32'h9243);
        reset     <= 1'b1;
        req_valid <= 1'b0;
        req       <= '0;
        rsp_ready <= 1'b0;
        fill_table();
        repeat (RESET_CYCLES) @(posedge core_clk);
        reset <= 1'b0;
        fork
            drive_requests();
            collect_responses();
        join
        check_value("err_count", 32'(err_count), 32'(count_rejects()));
        // No extra response once the last one is taken
        @(posedge core_clk);
        check_value("rsp_valid", 32'(rsp_valid), 32'd0);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/mbox_top_checker.sv
`timescale 1ns/1ns
`default_nettype none

module mbox_top_checker
    import mbox_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      req_valid,
    input  logic      req_ready,
    input  logic      rsp_valid,
    input  logic      rsp_ready,
    input  mbox_rsp_t rsp
);

    // Requests accepted but not yet answered
    logic [3:0] in_flight;

    always_ff @(posedge clk)
    begin
        if (reset)
            in_flight <= '0;
        else
            in_flight <= in_flight + 4'(req_valid && req_ready) - 4'(rsp_valid && rsp_ready);
    end

    rsp_held: assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else $error("rsp changed or dropped before it was accepted");

    out_of_reset: assert property (@(posedge clk)
        $fell(reset) |-> req_ready && !rsp_valid)
        else $error("Handshake state wrong in the first cycle after reset");

    rsp_after_req: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> in_flight != 0)
        else $error("Response presented without an outstanding request");

endmodule

bind mbox_top mbox_top_checker u_checker (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp)
);

`default_nettype wire

// File: design/mbox_top.sv
`timescale 1ns/1ns
`default_nettype none

module mbox_top
    import mbox_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    input  logic       req_valid,
    output logic       req_ready,
    input  mbox_req_t  req,

    output logic       rsp_valid,
    input  logic       rsp_ready,
    output mbox_rsp_t  rsp,

    output logic [7:0] err_count
);

    logic        dec_valid;
    logic        dec_ready;
    mbox_stage_t dec;

    logic        exe_valid;
    logic        exe_ready;
    mbox_rsp_t   exe;

    mbox_decode u_decode (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec       (dec)
    );

    // Lock state and mailbox memory live here
    mbox_execute u_execute (
        .clk       (clk),
        .reset     (reset),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec       (dec),
        .exe_valid (exe_valid),
        .exe_ready (exe_ready),
        .exe       (exe)
    );

    mbox_result u_result (
        .clk       (clk),
        .reset     (reset),
        .exe_valid (exe_valid),
        .exe_ready (exe_ready),
        .exe       (exe),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp),
        .err_count (err_count)
    );

endmodule

`default_nettype wire

// File: design/mbox_result.sv
`timescale 1ns/1ns
`default_nettype none

module mbox_result
    import mbox_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    // From execute
    input  logic       exe_valid,
    output logic       exe_ready,
    input  mbox_rsp_t  exe,

    // Response port
    output logic       rsp_valid,
    input  logic       rsp_ready,
    output mbox_rsp_t  rsp,

    output logic [7:0] err_count
);

    logic exe_fire;
    logic is_err;

    assign exe_ready = !rsp_valid || rsp_ready;
    assign exe_fire  = exe_valid && exe_ready;

    // Status view is only meaningful without read data
    assign is_err = !exe.is_data &&
                    ((exe.payload.stat.status == BUSY) ||
                     (exe.payload.stat.status == NOT_OWNER));

    always_ff @(posedge clk)
    begin
        if (reset)
            rsp_valid <= 1'b0;
        else if (exe_fire)
            rsp_valid <= 1'b1;
        else if (rsp_ready)
            rsp_valid <= 1'b0;
    end

    // Held stable until the requester takes it
    always_ff @(posedge clk)
    begin
        if (exe_fire)
            rsp <= exe;
    end

    // Saturating count of rejected commands
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            err_count <= '0;
        end
        else if (exe_fire && is_err && (err_count != 8'hff))
        begin
            err_count <= err_count + 8'd1;
        end
    end

endmodule

`default_nettype wire

// File: design/mbox_execute.sv
`timescale 1ns/1ns
`default_nettype none

`include "mbox_defs.svh"

module mbox_execute
    import mbox_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    // From decode
    input  logic        dec_valid,
    output logic        dec_ready,
    input  mbox_stage_t dec,

    // To result
    output logic        exe_valid,
    input  logic        exe_ready,
    output mbox_rsp_t   exe
);

    logic [`MBOX_DATA_W-1:0] mem [`MBOX_DEPTH];

    logic                    lock_held;
    logic [`MBOX_USER_W-1:0] owner;

    logic                    dec_fire;
    logic                    is_owner;
    logic                    nxt_held;
    logic [`MBOX_USER_W-1:0] nxt_owner;
    mbox_status_e            status;
    logic                    do_write;
    mbox_rsp_t               rsp_next;

    assign dec_ready = !exe_valid || exe_ready;
    assign dec_fire  = dec_valid && dec_ready;

    assign is_owner = lock_held && (owner == dec.user);

    // Lock rules
    always_comb
    begin
        nxt_held  = lock_held;
        nxt_owner = owner;
        status    = OK;
        do_write  = 1'b0;
        unique case (dec.op)
            LOCK:
            begin
                // Re-locking by the owner is harmless
                if (!lock_held || is_owner)
                begin
                    nxt_held  = 1'b1;
                    nxt_owner = dec.user;
                end
                else
                begin
                    status = BUSY;
                end
            end
            UNLOCK:
            begin
                if (is_owner)
                begin
                    nxt_held  = 1'b0;
                    nxt_owner = '0;
                end
                else
                begin
                    status = NOT_OWNER;
                end
            end
            WRITE:
            begin
                if (is_owner)
                    do_write = 1'b1;
                else
                    status = NOT_OWNER;
            end
            READ:
            begin
                if (!is_owner)
                    status = NOT_OWNER;
            end
        endcase
    end

    // Response word for the item entering the stage
    always_comb
    begin
        rsp_next.op      = dec.op;
        rsp_next.user    = dec.user;
        rsp_next.is_data = (dec.op == READ) && is_owner;
        if (rsp_next.is_data)
        begin
            rsp_next.payload.rd_data = mem[dec.addr];
        end
        else
        begin
            rsp_next.payload.stat.pad       = '0;
            rsp_next.payload.stat.status    = status;
            rsp_next.payload.stat.lock_held = nxt_held;
            rsp_next.payload.stat.owner     = nxt_owner;
        end
    end

    // State moves only when an item enters
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            lock_held <= 1'b0;
            owner     <= '0;
        end
        else if (dec_fire)
        begin
            lock_held <= nxt_held;
            owner     <= nxt_owner;
        end
    end

    always_ff @(posedge clk)
    begin
        if (dec_fire && do_write)
            mem[dec.addr] <= dec.data;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            exe_valid <= 1'b0;
        else if (dec_fire)
            exe_valid <= 1'b1;
        else if (exe_ready)
            exe_valid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (dec_fire)
            exe <= rsp_next;
    end

endmodule

`default_nettype wire

// File: design/mbox_decode.sv
`timescale 1ns/1ns
`default_nettype none

module mbox_decode
    import mbox_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    // Request port
    input  logic        req_valid,
    output logic        req_ready,
    input  mbox_req_t   req,

    // To execute
    output logic        dec_valid,
    input  logic        dec_ready,
    output mbox_stage_t dec
);

    logic req_fire;
    logic is_mem;

    // Slot frees up when empty or when its item moves on this edge
    assign req_ready = !dec_valid || dec_ready;
    assign req_fire  = req_valid && req_ready;

    // Memory access commands carry addr and data
    assign is_mem = (req.op == WRITE) || (req.op == READ);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            dec_valid <= 1'b0;
        end
        else if (req_fire)
        begin
            dec_valid <= 1'b1;
        end
        else if (dec_ready)
        begin
            dec_valid <= 1'b0;
        end
    end

    // Control commands get a clean payload
    always_ff @(posedge clk)
    begin
        if (req_fire)
        begin
            dec.op   <= req.op;
            dec.user <= req.user;
            if (is_mem)
            begin
                dec.addr <= req.addr;
                dec.data <= req.data;
            end
            else
            begin
                dec.addr <= '0;
                dec.data <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: common/mbox_pkg.sv
`default_nettype none

`include "mbox_defs.svh"

package mbox_pkg;

    // Command opcodes
    typedef enum logic [1:0] {
        LOCK   = 2'd0,
        UNLOCK = 2'd1,
        WRITE  = 2'd2,
        READ   = 2'd3
    } mbox_op_e;

    // Completion status, BAD_CMD is reserved
    typedef enum logic [1:0] {
        OK        = 2'd0,
        BUSY      = 2'd1,
        NOT_OWNER = 2'd2,
        BAD_CMD   = 2'd3
    } mbox_status_e;

    // Command word from the requester
    typedef struct packed {
        mbox_op_e                op;
        logic [`MBOX_USER_W-1:0] user;
        logic [`MBOX_ADDR_W-1:0] addr;
        logic [`MBOX_DATA_W-1:0] data;
    } mbox_req_t;

    // Decoded command held between decode and execute
    typedef struct packed {
        mbox_op_e                op;
        logic [`MBOX_USER_W-1:0] user;
        logic [`MBOX_ADDR_W-1:0] addr;
        logic [`MBOX_DATA_W-1:0] data;
    } mbox_stage_t;

    // Lock state after the command, packed into one data word
    typedef struct packed {
        logic [`MBOX_DATA_W-`MBOX_USER_W-4:0] pad;
        mbox_status_e                         status;
        logic                                 lock_held;
        logic [`MBOX_USER_W-1:0]              owner;
    } mbox_stat_t;

    // Read data for an owner READ, status record otherwise
    typedef union packed {
        logic [`MBOX_DATA_W-1:0] rd_data;
        mbox_stat_t              stat;
    } mbox_rsp_payload_u;

    typedef struct packed {
        mbox_op_e                op;
        logic [`MBOX_USER_W-1:0] user;
        logic                    is_data;
        mbox_rsp_payload_u       payload;
    } mbox_rsp_t;

endpackage

`default_nettype wire

// File: common/mbox_defs.svh
`ifndef MBOX_DEFS_SVH
`define MBOX_DEFS_SVH

// Mailbox memory geometry
`define MBOX_DEPTH 64

// Word address into the mailbox, log2 of the depth
`define MBOX_ADDR_W 6

// One mailbox word
`define MBOX_DATA_W 32

// Requester identity carried with every command
`define MBOX_USER_W 8

`endif
